/* hw/drbg_pkg.sv */
// Shared types and constants for the deterministic nonce generator
// Referenced by the RTL and the testbench model through drbg_pkg:: names
package drbg_pkg;

  // ----------------------------------------
  // Word types
  // ----------------------------------------
  typedef logic [63:0] word_t;  // K, V, seed, private key, hash, tag, nonce
  typedef logic [7:0]  sep_t;   // Domain separator byte
  typedef logic [2:0]  cnt_t;   // Absorbed word count, 1 to 4

  // Request type latched at start
  typedef enum logic {
    mode_keygen = 1'b0,
    mode_sign   = 1'b1
  } drbg_mode_e;

  // Mixing step requested by the controller
  typedef enum logic [2:0] {
    step_k_sep0   = 3'd0,  // K = F_K(V || 0x00 || data)
    step_k_sep1   = 3'd1,  // K = F_K(V || 0x01 || data)
    step_v        = 3'd2,  // V = F_K(V)
    step_k_reseed = 3'd3   // K = F_K(V || 0x00)
  } drbg_step_e;

  // ----------------------------------------
  // Engine request
  // ----------------------------------------
  typedef struct packed {
    word_t       key;    // Mixing key, the current K
    word_t [3:0] msg;    // msg[0] is absorbed first
    cnt_t        count;  // Words in use
  } prf_req_t;

  // ----------------------------------------
  // DRBG constants
  // ----------------------------------------
  localparam word_t K_INIT  = 64'h0000_0000_0000_0000;
  localparam word_t V_INIT  = 64'h0101_0101_0101_0101;
  localparam word_t Q_ORDER = 64'h3FFF_FFFF_FFFF_FFC5;  // Upper bound of the nonce range

  localparam sep_t SEP_ZERO = 8'h00;
  localparam sep_t SEP_ONE  = 8'h01;

  localparam int ROT_AMOUNT = 13;  // Left rotation per round

endpackage

/* hw/prf_core.sv */
// Keyed mixing engine standing in for the HMAC core
// Latches a request on prf_start, absorbs 1 to 4 words and pulses tag_valid
// Latency is count * ROUNDS + 1 cycles from prf_start
module prf_core #(
  parameter int ROUNDS = 4
) (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               prf_start,
  input  drbg_pkg::prf_req_t req,
  output drbg_pkg::word_t    tag,
  output logic               tag_valid
);

  localparam int RW = (ROUNDS > 1) ? $clog2(ROUNDS) : 1;

  drbg_pkg::prf_req_t req_q;      // Latched request
  drbg_pkg::word_t    state_q;    // Mixing state, the tag when done
  drbg_pkg::word_t    round_out;
  logic               busy_q;
  logic [1:0]         word_idx_q; // Word being mixed
  logic [RW-1:0]      round_q;
  logic               tag_valid_q;
  logic               last_round;
  logic               last_word;

  // One round: rotate left, XOR with state plus key
  function automatic drbg_pkg::word_t mix_round(
    input drbg_pkg::word_t s,
    input drbg_pkg::word_t k
  );
    drbg_pkg::word_t rot;
    rot = (s << drbg_pkg::ROT_AMOUNT) |
          (s >> ($bits(drbg_pkg::word_t) - drbg_pkg::ROT_AMOUNT));
    return rot ^ (s + k);  // Sum wraps mod 2^64
  endfunction

  assign round_out  = mix_round(state_q, req_q.key);
  assign last_round = (round_q == RW'(ROUNDS - 1));
  assign last_word  = ({1'b0, word_idx_q} == req_q.count - 3'd1);

  // ----------------------------------------
  // Datapath
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (prf_start)
    begin
      req_q   <= req;
      state_q <= req.key ^ req.msg[0];  // State starts at key, first word folded in
    end
    else if (busy_q)
    begin
      if (last_round && !last_word)
        state_q <= round_out ^ req_q.msg[word_idx_q + 2'd1];
      else
        state_q <= round_out;
    end
  end

  // ----------------------------------------
  // Word and round sequencing
  // ----------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      busy_q      <= 1'b0;
      word_idx_q  <= 2'd0;
      round_q     <= '0;
      tag_valid_q <= 1'b0;
    end
    else
    begin
      tag_valid_q <= 1'b0;
      if (prf_start)
      begin
        busy_q     <= 1'b1;
        word_idx_q <= 2'd0;
        round_q    <= '0;
      end
      else if (busy_q)
      begin
        if (last_round)
        begin
          round_q <= '0;
          if (last_word)
          begin
            busy_q      <= 1'b0;
            tag_valid_q <= 1'b1;  // Tag lands in state_q on this edge
          end
          else
          begin
            word_idx_q <= word_idx_q + 2'd1;
          end
        end
        else
        begin
          round_q <= round_q + 1'b1;
        end
      end
    end
  end

  assign tag       = state_q;
  assign tag_valid = tag_valid_q;

endmodule

/* hw/drbg_state.sv */
// DRBG datapath with the K, V and nonce registers
// Builds the engine message for each step, stores the returned tag and
// checks the candidate range for the sign procedure
module drbg_state (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 start_accept,
  input  drbg_pkg::drbg_mode_e mode,
  input  drbg_pkg::word_t      seed,
  input  drbg_pkg::word_t      priv_key,
  input  drbg_pkg::word_t      h1,
  input  drbg_pkg::drbg_step_e step,
  input  logic                 step_start,
  input  logic                 finish,
  input  drbg_pkg::word_t      tag,
  input  logic                 tag_valid,
  output drbg_pkg::prf_req_t   req,
  output logic                 prf_start,
  output logic                 candidate_ok,
  output drbg_pkg::word_t      nonce
);

  drbg_pkg::word_t      k_q;
  drbg_pkg::word_t      v_q;
  drbg_pkg::word_t      d0_q;     // Seed or private key
  drbg_pkg::word_t      d1_q;     // Hash, zero in keygen
  drbg_pkg::word_t      nonce_q;
  drbg_pkg::drbg_mode_e mode_q;
  drbg_pkg::drbg_step_e step_q;   // Step in flight in the engine
  drbg_pkg::sep_t       sep;

  // ----------------------------------------
  // Message building
  // ----------------------------------------
  always_comb
  begin
    sep        = (step == drbg_pkg::step_k_sep1) ? drbg_pkg::SEP_ONE : drbg_pkg::SEP_ZERO;
    req        = '0;
    req.key    = k_q;
    req.msg[0] = v_q;  // Every step starts with V
    case (step)
      drbg_pkg::step_k_sep0,
      drbg_pkg::step_k_sep1:
      begin
        req.msg[1] = drbg_pkg::word_t'(sep);
        req.msg[2] = d0_q;
        req.msg[3] = d1_q;
        req.count  = (mode_q == drbg_pkg::mode_sign) ? 3'd4 : 3'd3;
      end
      drbg_pkg::step_k_reseed:
      begin
        req.msg[1] = drbg_pkg::word_t'(drbg_pkg::SEP_ZERO);
        req.count  = 3'd2;
      end
      default:
      begin
        req.count = 3'd1;  // V alone
      end
    endcase
  end

  assign prf_start = step_start;

  // ----------------------------------------
  // K, V and captured inputs
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (start_accept)
    begin
      k_q <= drbg_pkg::K_INIT;
      v_q <= drbg_pkg::V_INIT;
      if (mode == drbg_pkg::mode_sign)
      begin
        d0_q <= priv_key;
        d1_q <= h1;
      end
      else
      begin
        d0_q <= seed;
        d1_q <= '0;
      end
    end
    else if (tag_valid)
    begin
      if (step_q == drbg_pkg::step_v)
        v_q <= tag;
      else
        k_q <= tag;  // All other steps update K
    end
  end

  // Mode, pending step and output nonce
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      mode_q  <= drbg_pkg::mode_keygen;
      step_q  <= drbg_pkg::step_v;
      nonce_q <= '0;
    end
    else
    begin
      if (start_accept)
        mode_q <= mode;
      if (step_start)
        step_q <= step;
      if (finish)
        nonce_q <= v_q;  // Held until the next result
    end
  end

  // Candidate must lie in 1 .. Q-1
  assign candidate_ok = (v_q != '0) && (v_q < drbg_pkg::Q_ORDER);
  assign nonce        = nonce_q;

endmodule

/* hw/drbg_ctrl.sv */
// Sequencer for the keygen and sign procedures
// Issues one mixing step at a time and waits for its tag before the next
module drbg_ctrl (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 start,
  input  drbg_pkg::drbg_mode_e mode,
  input  logic                 tag_valid,
  input  logic                 candidate_ok,
  output logic                 start_accept,
  output drbg_pkg::drbg_step_e step,
  output logic                 step_start,
  output logic                 finish,
  output logic                 ready,
  output logic                 valid
);

  typedef enum logic [2:0] {
    st_idle = 3'd0,
    st_k1   = 3'd1,  // K from V, 0x00, data
    st_v1   = 3'd2,
    st_k2   = 3'd3,  // K from V, 0x01, data
    st_v2   = 3'd4,
    st_draw = 3'd5,  // New candidate in V
    st_rs_k = 3'd6,  // Reseed K
    st_rs_v = 3'd7
  } ctrl_state_e;

  ctrl_state_e          state_q;
  ctrl_state_e          state_nxt;
  drbg_pkg::drbg_mode_e mode_q;
  logic                 go_q;     // Decide and launch this cycle
  logic                 valid_q;

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  // Evaluated in the go cycle, one cycle after a tag is stored, so the
  // range test already sees the new V
  always_comb
  begin
    state_nxt = st_idle;
    case (state_q)
      st_idle: state_nxt = st_k1;
      st_k1:   state_nxt = st_v1;
      st_v1:   state_nxt = st_k2;
      st_k2:   state_nxt = st_v2;
      st_v2:   state_nxt = (mode_q == drbg_pkg::mode_sign) ? st_draw : st_idle;
      st_draw: state_nxt = candidate_ok ? st_idle : st_rs_k;
      st_rs_k: state_nxt = st_rs_v;
      st_rs_v: state_nxt = st_draw;  // Draw again after the reseed
      default: state_nxt = st_idle;
    endcase
  end

  // Step issued for the state being entered
  always_comb
  begin
    case (state_nxt)
      st_k1:   step = drbg_pkg::step_k_sep0;
      st_k2:   step = drbg_pkg::step_k_sep1;
      st_rs_k: step = drbg_pkg::step_k_reseed;
      default: step = drbg_pkg::step_v;
    endcase
  end

  // ----------------------------------------
  // Handshake outputs
  // ----------------------------------------
  assign ready        = (state_q == st_idle) && !go_q && !valid_q;
  assign start_accept = start && ready;  // Ignored while busy
  assign step_start   = go_q && (state_nxt != st_idle);
  assign finish       = go_q && (state_nxt == st_idle);
  assign valid        = valid_q;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q <= st_idle;
      mode_q  <= drbg_pkg::mode_keygen;
      go_q    <= 1'b0;
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= finish;  // Nonce register is loaded by then
      if (start_accept)
      begin
        mode_q <= mode;
        go_q   <= 1'b1;  // First step after K and V are initialised
      end
      else if (go_q)
      begin
        state_q <= state_nxt;
        go_q    <= 1'b0;
      end
      else if (tag_valid)
      begin
        go_q <= 1'b1;
      end
    end
  end

endmodule

/* hw/drbg_top.sv */
// Top level of the nonce generator
// Connects the sequencer, the DRBG datapath and the mixing engine
module drbg_top #(
  parameter int ROUNDS = 4  // Rounds per absorbed word
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 start,
  input  drbg_pkg::drbg_mode_e mode,
  input  drbg_pkg::word_t      seed,
  input  drbg_pkg::word_t      priv_key,
  input  drbg_pkg::word_t      h1,
  output logic                 ready,
  output logic                 valid,
  output drbg_pkg::word_t      nonce
);

  logic                 start_accept;
  logic                 step_start;
  logic                 finish;
  logic                 candidate_ok;
  logic                 prf_start;
  logic                 tag_valid;
  drbg_pkg::drbg_step_e step;
  drbg_pkg::prf_req_t   req;
  drbg_pkg::word_t      tag;

  drbg_ctrl i_ctrl (
    .clk          (clk),
    .reset_n      (reset_n),
    .start        (start),
    .mode         (mode),
    .tag_valid    (tag_valid),
    .candidate_ok (candidate_ok),
    .start_accept (start_accept),
    .step         (step),
    .step_start   (step_start),
    .finish       (finish),
    .ready        (ready),
    .valid        (valid)
  );

  drbg_state i_state (
    .clk          (clk),
    .reset_n      (reset_n),
    .start_accept (start_accept),
    .mode         (mode),
    .seed         (seed),
    .priv_key     (priv_key),
    .h1           (h1),
    .step         (step),
    .step_start   (step_start),
    .finish       (finish),
    .tag          (tag),
    .tag_valid    (tag_valid),
    .req          (req),
    .prf_start    (prf_start),
    .candidate_ok (candidate_ok),
    .nonce        (nonce)
  );

  prf_core #(
    .ROUNDS (ROUNDS)
  ) i_prf (
    .clk       (clk),
    .reset_n   (reset_n),
    .prf_start (prf_start),
    .req       (req),
    .tag       (tag),
    .tag_valid (tag_valid)
  );

endmodule

/* include/drbg_model.svh */
// Reference model of the mixing engine and both DRBG procedures
// Included inside the testbench module, which passes its round count
`ifndef DRBG_MODEL_SVH
`define DRBG_MODEL_SVH

// Single round, same rule as the engine
function automatic drbg_pkg::word_t model_round(input drbg_pkg::word_t s,
                                                input drbg_pkg::word_t k);
  drbg_pkg::word_t rot;
  rot = (s << drbg_pkg::ROT_AMOUNT) |
        (s >> ($bits(drbg_pkg::word_t) - drbg_pkg::ROT_AMOUNT));
  return rot ^ (s + k);
endfunction

// Full mixing of one request
function automatic drbg_pkg::word_t model_prf(input drbg_pkg::prf_req_t req,
                                              input int rounds);
  drbg_pkg::word_t s;
  s = req.key;
  for (int i = 0; i < int'(req.count); i++)
  begin
    s = s ^ req.msg[i];
    for (int r = 0; r < rounds; r++)
      s = model_round(s, req.key);
  end
  return s;
endfunction

// K update with separator and data, or the reseed form when count is 2
function automatic drbg_pkg::word_t model_k_step(input drbg_pkg::word_t k,
                                                 input drbg_pkg::word_t v,
                                                 input drbg_pkg::sep_t sep,
                                                 input drbg_pkg::word_t d0,
                                                 input drbg_pkg::word_t d1,
                                                 input drbg_pkg::cnt_t count,
                                                 input int rounds);
  drbg_pkg::prf_req_t req;
  req        = '0;
  req.key    = k;
  req.msg[0] = v;
  req.msg[1] = drbg_pkg::word_t'(sep);
  req.msg[2] = d0;
  req.msg[3] = d1;
  req.count  = count;
  return model_prf(req, rounds);
endfunction

// V update from V alone
function automatic drbg_pkg::word_t model_v_step(input drbg_pkg::word_t k,
                                                 input drbg_pkg::word_t v,
                                                 input int rounds);
  drbg_pkg::prf_req_t req;
  req        = '0;
  req.key    = k;
  req.msg[0] = v;
  req.count  = 3'd1;
  return model_prf(req, rounds);
endfunction

function automatic drbg_pkg::word_t model_keygen(input drbg_pkg::word_t seed,
                                                 input int rounds);
  drbg_pkg::word_t k;
  drbg_pkg::word_t v;
  k = drbg_pkg::K_INIT;
  v = drbg_pkg::V_INIT;
  k = model_k_step(k, v, drbg_pkg::SEP_ZERO, seed, '0, 3'd3, rounds);
  v = model_v_step(k, v, rounds);
  k = model_k_step(k, v, drbg_pkg::SEP_ONE, seed, '0, 3'd3, rounds);
  v = model_v_step(k, v, rounds);
  return v;
endfunction

function automatic drbg_pkg::word_t model_sign(input drbg_pkg::word_t priv_key,
                                               input drbg_pkg::word_t h1,
                                               input int rounds);
  drbg_pkg::word_t k;
  drbg_pkg::word_t v;
  k = drbg_pkg::K_INIT;
  v = drbg_pkg::V_INIT;
  k = model_k_step(k, v, drbg_pkg::SEP_ZERO, priv_key, h1, 3'd4, rounds);
  v = model_v_step(k, v, rounds);
  k = model_k_step(k, v, drbg_pkg::SEP_ONE, priv_key, h1, 3'd4, rounds);
  v = model_v_step(k, v, rounds);
  v = model_v_step(k, v, rounds);  // First draw
  while (v == '0 || v >= drbg_pkg::Q_ORDER)
  begin
    k = model_k_step(k, v, drbg_pkg::SEP_ZERO, '0, '0, 3'd2, rounds);
    v = model_v_step(k, v, rounds);
    v = model_v_step(k, v, rounds);  // Redraw
  end
  return v;
endfunction

`endif

/* testbench/tb_drbg.sv */
// Testbench for the nonce generator top level
// Sends random keygen and sign requests and compares each nonce with the model
module tb_drbg;

  localparam int ROUNDS        = 4;
  localparam int READY_TIMEOUT = 100;
  localparam int VALID_TIMEOUT = 5000;  // Room for long reseed chains

  logic                 clk;
  logic                 reset_n;
  logic                 start;
  drbg_pkg::drbg_mode_e mode;
  drbg_pkg::word_t      seed;
  drbg_pkg::word_t      priv_key;
  drbg_pkg::word_t      h1;
  logic                 ready;
  logic                 valid;
  drbg_pkg::word_t      nonce;
  logic [63:0]          lcg_state;
  drbg_pkg::word_t      held_nonce;  // Last expected nonce

  `include "drbg_model.svh"

  drbg_top #(
    .ROUNDS (ROUNDS)
  ) i_dut (
    .clk      (clk),
    .reset_n  (reset_n),
    .start    (start),
    .mode     (mode),
    .seed     (seed),
    .priv_key (priv_key),
    .h1       (h1),
    .ready    (ready),
    .valid    (valid),
    .nonce    (nonce)
  );

  always #10 clk = ~clk;

  // ----------------------------------------
  // Random numbers
  // ----------------------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcg_state[63:32];  // Upper half has the better bits
  endfunction

  function automatic drbg_pkg::word_t rand_word();
    drbg_pkg::word_t w;
    w[63:32] = next_rand();
    w[31:0]  = next_rand();
    return w;
  endfunction

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_nonce(input drbg_pkg::word_t got, input drbg_pkg::word_t exp,
                             input string what);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s, got %b, expected %b", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t: no %s within the allowed number of cycles", $time, what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // ----------------------------------------
  // Waits sampled at the falling edge
  // ----------------------------------------
  task automatic wait_ready();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!ready)
    begin
      cycles++;
      if (cycles > READY_TIMEOUT)
        report_timeout("ready after the previous request");
      @(negedge clk);
    end
  endtask

  task automatic wait_valid();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!valid)
    begin
      check_flag(ready, 1'b0, "ready while busy");
      check_nonce(nonce, held_nonce, "nonce held during request");
      cycles++;
      if (cycles > VALID_TIMEOUT)
        report_timeout("valid for the running request");
      @(negedge clk);
    end
  endtask

  // One request with an optional second start while busy
  task automatic run_request(input drbg_pkg::drbg_mode_e m, input drbg_pkg::word_t d0,
                             input drbg_pkg::word_t d1, input drbg_pkg::word_t d2,
                             input logic inject);
    drbg_pkg::word_t exp;
    logic            in_range;
    exp = (m == drbg_pkg::mode_sign) ? model_sign(d1, d2, ROUNDS) : model_keygen(d0, ROUNDS);
    wait_ready();
    @(posedge clk);
    start    <= 1'b1;
    mode     <= m;
    seed     <= d0;
    priv_key <= d1;
    h1       <= d2;
    @(posedge clk);
    start <= 1'b0;
    if (inject)
    begin
      @(posedge clk);
      start    <= 1'b1;  // Must be ignored
      mode     <= (m == drbg_pkg::mode_sign) ? drbg_pkg::mode_keygen : drbg_pkg::mode_sign;
      seed     <= ~d0;
      priv_key <= d1 ^ 64'h5A5A_5A5A_5A5A_5A5A;
      h1       <= ~d2;
      @(posedge clk);
      start <= 1'b0;
    end
    wait_valid();
    if (m == drbg_pkg::mode_sign)
    begin
      in_range = (nonce != '0) && (nonce < drbg_pkg::Q_ORDER);
      check_flag(in_range, 1'b1, "sign nonce inside 1 .. Q-1");
    end
    check_nonce(nonce, exp, (m == drbg_pkg::mode_sign) ? "sign nonce" : "keygen nonce");
    check_flag(ready, 1'b0, "ready in the valid cycle");
    held_nonce = exp;
    @(negedge clk);
    check_flag(valid, 1'b0, "valid after one cycle");
    check_flag(ready, 1'b1, "ready in the cycle after valid");
    check_nonce(nonce, held_nonce, "nonce after valid");
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial
  begin
    clk        = 1'b0;
    reset_n    = 1'b0;
    start      = 1'b0;
    mode       = drbg_pkg::mode_keygen;
    seed       = '0;
    priv_key   = '0;
    h1         = '0;
    lcg_state  = 64'd50516;
    held_nonce = '0;
    repeat (10) @(posedge clk);
    reset_n <= 1'b1;

    // Idle behavior straight after reset
    repeat (5)
    begin
      @(negedge clk);
      check_flag(ready, 1'b1, "ready after reset");
      check_flag(valid, 1'b0, "valid after reset");
      check_nonce(nonce, '0, "nonce after reset");
    end

    for (int i = 0; i < 20; i++)
      run_request(drbg_pkg::mode_keygen, rand_word(), rand_word(), rand_word(), i % 4 == 1);
    for (int i = 0; i < 20; i++)
      run_request(drbg_pkg::mode_sign, rand_word(), rand_word(), rand_word(), i % 4 == 2);

    $display("Simulation passed");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
hw/drbg_pkg.sv
hw/prf_core.sv
hw/drbg_state.sv
hw/drbg_ctrl.sv
hw/drbg_top.sv
testbench/tb_drbg.sv
